/* common/bp_macros.svh */
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// fetch line geometry
`define BP_SLOTS 4
`define BP_LINE_BITS (`BP_SLOTS * bp_pkg::INSTR_W)

// gshare sizing, pht index is as wide as the history
`define BP_GHR_BITS 8
`define BP_PHT_ENTRIES (1 << `BP_GHR_BITS)

// return address stack entries, power of two for pointer wrap
`define BP_RAS_DEPTH 8

`define BP_RESET_PC 64'h0

`endif

/* common/bp_pkg.sv */
package bp_pkg;

  localparam int INSTR_W = 32; // one A64 instruction word
  localparam int PC_W    = 64;
  localparam int IMM26_W = 26; // B / BL offset, bits 25:0
  localparam int IMM19_W = 19; // B.cond offset, bits 23:5

  // opcode match values, compared against the top bits of a slot
  localparam logic [10:0] OPC_RET   = 11'b11010110010; // bits 31:21
  localparam logic [5:0]  OPC_B     = 6'b000101;       // bits 31:26
  localparam logic [5:0]  OPC_BL    = 6'b100101;       // bits 31:26
  localparam logic [7:0]  OPC_BCOND = 8'b01010100;     // bits 31:24

  // branch class of one fetch slot
  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_b    = 3'd1,
    br_bl   = 3'd2, // call, pushes return address
    br_ret  = 3'd3, // return, pops
    br_cond = 3'd4
  } br_kind_e;

endpackage

/* branch_pred/bp_predecode.sv */
`include "bp_macros.svh"

module bp_predecode (
  input  logic [`BP_LINE_BITS-1:0]  line_data,
  input  logic [bp_pkg::PC_W-1:0]   line_pc,
  output bp_pkg::br_kind_e          slot_kind [`BP_SLOTS],
  output logic [bp_pkg::PC_W-1:0]   slot_target [`BP_SLOTS]
);

  localparam int SLOT_BITS = $clog2(`BP_SLOTS);
  localparam int OFS_BITS  = SLOT_BITS + 2; // byte offset within the line
  localparam int EXT_B     = bp_pkg::PC_W - bp_pkg::IMM26_W - 2;
  localparam int EXT_C     = bp_pkg::PC_W - bp_pkg::IMM19_W - 2;

  logic [SLOT_BITS-1:0] start_slot; // first slot the fetch actually wants

  assign start_slot = line_pc[OFS_BITS-1:2];

  for (genvar k = 0; k < `BP_SLOTS; k++) begin : g_slot
    logic [bp_pkg::INSTR_W-1:0] instr;
    logic [bp_pkg::PC_W-1:0]    slot_pc;
    logic [bp_pkg::PC_W-1:0]    off_b;   // sext(imm26) << 2
    logic [bp_pkg::PC_W-1:0]    off_c;   // sext(imm19) << 2
    bp_pkg::br_kind_e           kind;

    assign instr   = line_data[k*bp_pkg::INSTR_W +: bp_pkg::INSTR_W];
    assign slot_pc = {line_pc[bp_pkg::PC_W-1:OFS_BITS], SLOT_BITS'(k), 2'b00};

    assign off_b = {{EXT_B{instr[25]}}, instr[25:0], 2'b00};
    assign off_c = {{EXT_C{instr[23]}}, instr[23:5], 2'b00};

    // opcode match, ret checked first since its field is widest
    always_comb begin
      kind = bp_pkg::br_none;
      if (k >= start_slot) begin // earlier slots were already consumed
        if (instr[31:21] == bp_pkg::OPC_RET) begin
          kind = bp_pkg::br_ret;
        end else if (instr[31:26] == bp_pkg::OPC_B) begin
          kind = bp_pkg::br_b;
        end else if (instr[31:26] == bp_pkg::OPC_BL) begin
          kind = bp_pkg::br_bl;
        end else if (instr[31:24] == bp_pkg::OPC_BCOND) begin
          kind = bp_pkg::br_cond;
        end
      end
    end

    assign slot_kind[k] = kind;
    // ret target comes from the ras, this value is ignored for it
    assign slot_target[k] = (kind == bp_pkg::br_cond) ? slot_pc + off_c
                                                      : slot_pc + off_b;
  end

endmodule

/* branch_pred/bp_gshare.sv */
`include "bp_macros.svh"

module bp_gshare (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  logic [bp_pkg::PC_W-1:0]   line_pc,
  output logic [`BP_SLOTS-1:0]      slot_taken,
  input  logic                      x_valid,
  input  logic [bp_pkg::PC_W-1:0]   x_pc,
  input  logic                      x_taken
);

  localparam int SLOT_BITS = $clog2(`BP_SLOTS);
  localparam int IDX_W     = `BP_GHR_BITS;

  logic [1:0]       pht [`BP_PHT_ENTRIES]; // 2-bit saturating counters
  logic [IDX_W-1:0] ghr;                   // committed history, newest in bit 0
  logic [IDX_W-1:0] x_idx;
  logic [1:0]       x_ctr;

  // four parallel lookups, one per slot of the line
  for (genvar k = 0; k < `BP_SLOTS; k++) begin : g_lookup
    logic [IDX_W-1:0] idx;

    // slot pc bits 9:2 are the line pc bits above the offset plus slot number
    assign idx = {line_pc[IDX_W+1:SLOT_BITS+2], SLOT_BITS'(k)} ^ ghr;
    assign slot_taken[k] = pht[idx][1]; // msb set means 2 or 3
  end

  // training port
  assign x_idx = x_pc[IDX_W+1:2] ^ ghr; // same hash, pre-update history
  assign x_ctr = pht[x_idx];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
        pht[i] <= 2'b01; // weakly not taken
      end
    end else if (x_valid) begin
      if (x_taken && x_ctr != 2'b11) begin
        pht[x_idx] <= x_ctr + 2'd1;
      end else if (!x_taken && x_ctr != 2'b00) begin
        pht[x_idx] <= x_ctr - 2'd1;
      end
      ghr <= {ghr[IDX_W-2:0], x_taken}; // shift in the outcome
    end
  end

endmodule

/* branch_pred/bp_ras.sv */
`include "bp_macros.svh"

module bp_ras (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  logic                      push,
  input  logic                      pop,
  input  logic [bp_pkg::PC_W-1:0]   push_addr,
  output logic [bp_pkg::PC_W-1:0]   top
);

  localparam int PTR_W = $clog2(`BP_RAS_DEPTH);
  localparam int CNT_W = $clog2(`BP_RAS_DEPTH + 1);

  logic [bp_pkg::PC_W-1:0] stack_q [`BP_RAS_DEPTH];
  logic [PTR_W-1:0]        ptr;     // next free entry
  logic [CNT_W-1:0]        count;   // live entries, saturates at depth
  logic [PTR_W-1:0]        top_ptr;

  assign top_ptr = ptr - 1'b1;
  assign top     = (count != '0) ? stack_q[top_ptr] : '0; // empty reads zero

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ptr   <= '0;
      count <= '0;
    end else if (push) begin
      ptr <= ptr + 1'b1; // wraps, overwriting the oldest when full
      if (count != CNT_W'(`BP_RAS_DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop && count != '0) begin // pop on empty ignored
      ptr   <= top_ptr;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) stack_q[ptr] <= push_addr;
  end

endmodule

/* branch_pred/bp_next_pc.sv */
`include "bp_macros.svh"

module bp_next_pc (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  logic                      line_valid,
  input  logic [bp_pkg::PC_W-1:0]   line_pc,
  input  bp_pkg::br_kind_e          slot_kind [`BP_SLOTS],
  input  logic [bp_pkg::PC_W-1:0]   slot_target [`BP_SLOTS],
  input  logic [`BP_SLOTS-1:0]      slot_taken,
  input  logic [bp_pkg::PC_W-1:0]   ras_top,
  input  logic                      x_redirect,
  input  logic [bp_pkg::PC_W-1:0]   x_target,
  output logic                      ras_push,
  output logic                      ras_pop,
  output logic [bp_pkg::PC_W-1:0]   ras_push_addr,
  output logic [bp_pkg::PC_W-1:0]   pred_pc,
  output logic                      pc_valid,
  output bp_pkg::br_kind_e          pred_kind
);

  localparam int SLOT_BITS = $clog2(`BP_SLOTS);
  localparam int OFS_BITS  = SLOT_BITS + 2;

  logic [bp_pkg::PC_W-1:0] next_pc;
  bp_pkg::br_kind_e        next_kind;
  logic [SLOT_BITS-1:0]    hit_slot; // slot that ended the line
  logic                    accept;

  assign accept = line_valid && !x_redirect; // redirect squashes the line

  // priority scan, lowest slot that redirects wins
  always_comb begin
    logic found;
    logic redirects;
    found     = 1'b0;
    redirects = 1'b0;
    hit_slot  = '0;
    next_kind = bp_pkg::br_none;
    // sequential fall-through to the next line
    next_pc   = {line_pc[bp_pkg::PC_W-1:OFS_BITS] + 1'b1, {OFS_BITS{1'b0}}};
    for (int k = 0; k < `BP_SLOTS; k++) begin
      // untaken b.cond keeps scanning
      redirects = (slot_kind[k] == bp_pkg::br_b) ||
                  (slot_kind[k] == bp_pkg::br_bl) ||
                  (slot_kind[k] == bp_pkg::br_ret) ||
                  (slot_kind[k] == bp_pkg::br_cond && slot_taken[k]);
      if (!found && redirects) begin
        found     = 1'b1;
        hit_slot  = SLOT_BITS'(k);
        next_kind = slot_kind[k];
        next_pc   = (slot_kind[k] == bp_pkg::br_ret) ? ras_top : slot_target[k];
      end
    end
  end

  // ras side effects only for a line that is really taken
  assign ras_push      = accept && (next_kind == bp_pkg::br_bl);
  assign ras_pop       = accept && (next_kind == bp_pkg::br_ret);
  assign ras_push_addr = {line_pc[bp_pkg::PC_W-1:OFS_BITS], hit_slot, 2'b00} + 3'd4;

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pred_pc   <= `BP_RESET_PC;
      pc_valid  <= 1'b0;
      pred_kind <= bp_pkg::br_none;
    end else begin
      pc_valid <= line_valid || x_redirect; // one cycle after either pulse
      if (x_redirect) begin
        pred_pc   <= x_target; // execute correction wins
        pred_kind <= bp_pkg::br_none;
      end else if (line_valid) begin
        pred_pc   <= next_pc;
        pred_kind <= next_kind;
      end
    end
  end

endmodule

/* hw/fetch_predictor.sv */
`include "bp_macros.svh"

module fetch_predictor (
  input  logic                      clk_in,
  input  logic                      rst_N_in,
  input  logic                      line_valid,
  input  logic [`BP_LINE_BITS-1:0]  line_data,
  input  logic [bp_pkg::PC_W-1:0]   line_pc,
  input  logic                      x_valid,
  input  logic [bp_pkg::PC_W-1:0]   x_pc,
  input  logic                      x_taken,
  input  logic                      x_redirect,
  input  logic [bp_pkg::PC_W-1:0]   x_target,
  output logic [bp_pkg::PC_W-1:0]   pred_pc,
  output logic                      pc_valid,
  output bp_pkg::br_kind_e          pred_kind
);

  bp_pkg::br_kind_e        slot_kind [`BP_SLOTS];
  logic [bp_pkg::PC_W-1:0] slot_target [`BP_SLOTS];
  logic [`BP_SLOTS-1:0]    slot_taken;
  logic                    ras_push;
  logic                    ras_pop;
  logic [bp_pkg::PC_W-1:0] ras_push_addr;
  logic [bp_pkg::PC_W-1:0] ras_top;

  // predecode and gshare look at the same line in parallel
  bp_predecode predecode_i (
    .line_data  (line_data),
    .line_pc    (line_pc),
    .slot_kind  (slot_kind),
    .slot_target(slot_target)
  );

  bp_gshare gshare_i (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .line_pc   (line_pc),
    .slot_taken(slot_taken),
    .x_valid   (x_valid),
    .x_pc      (x_pc),
    .x_taken   (x_taken)
  );

  bp_ras ras_i (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .push     (ras_push),
    .pop      (ras_pop),
    .push_addr(ras_push_addr),
    .top      (ras_top)
  );

  bp_next_pc next_pc_i (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .line_valid   (line_valid),
    .line_pc      (line_pc),
    .slot_kind    (slot_kind),
    .slot_target  (slot_target),
    .slot_taken   (slot_taken),
    .ras_top      (ras_top),
    .x_redirect   (x_redirect),
    .x_target     (x_target),
    .ras_push     (ras_push),
    .ras_pop      (ras_pop),
    .ras_push_addr(ras_push_addr),
    .pred_pc      (pred_pc),
    .pc_valid     (pc_valid),
    .pred_kind    (pred_kind)
  );

endmodule

/* sim/fetch_predictor_sva.sv */
`include "bp_macros.svh"

module fetch_predictor_sva #(
  parameter logic [7:0] TRACK_IDX = 8'hfe // pht entry mirrored by ctr_m
) (
  input logic                     clk_in,
  input logic                     rst_N_in,
  input logic                     line_valid,
  input logic [`BP_LINE_BITS-1:0] line_data,
  input logic [63:0]              line_pc,
  input logic                     x_valid,
  input logic [63:0]              x_pc,
  input logic                     x_taken,
  input logic                     x_redirect,
  input logic [63:0]              x_target,
  input logic [63:0]              pred_pc,
  input logic                     pc_valid,
  input bp_pkg::br_kind_e         pred_kind
);

  int               fail_count = 0;
  logic [63:0]      ras_m [$];  // return stack model, newest at the back
  logic [7:0]       ghr_m;
  logic [1:0]       ctr_m;      // mirror of pht[TRACK_IDX]
  logic [255:0]     trained;    // entries that may have left the reset value
  logic             armed;      // a pulse was taken on the last edge
  logic             started;
  logic             exp_known;  // low when an unmirrored counter decided the line
  logic [63:0]      exp_pc;
  bp_pkg::br_kind_e exp_kind;

  always @(posedge clk_in) begin
    logic [31:0]      ins;
    logic [63:0]      spc;
    logic [63:0]      hit_pc;
    logic [7:0]       idx;
    bp_pkg::br_kind_e kd;
    kd = bp_pkg::br_none;
    hit_pc = '0;
    if (rst_N_in) begin
      ras_m.delete();
      ghr_m   <= '0;
      ctr_m   <= 2'd1; // weakly not taken
      trained <= '0;
      armed   <= 1'b0;
      started <= 1'b0;
    end else begin
      armed     <= line_valid || x_redirect;
      started   <= started || line_valid || x_redirect;
      exp_known <= 1'b1;
      exp_kind  <= bp_pkg::br_none;
      exp_pc    <= x_redirect ? x_target : {line_pc[63:4] + 60'd1, 4'h0};
      // scan from the start slot, kd doubles as the hit flag
      for (int k = 0; k < 4; k++) begin
        ins = line_data[32*k +: 32];
        spc = {line_pc[63:4], 4'(4 * k)};
        idx = spc[9:2] ^ ghr_m;
        if (line_valid && !x_redirect && kd == bp_pkg::br_none &&
            k >= line_pc[3:2]) begin
          if (ins[31:21] == 11'h6b2) kd = bp_pkg::br_ret;
          else if (ins[31:26] == 6'h05) kd = bp_pkg::br_b;
          else if (ins[31:26] == 6'h25) kd = bp_pkg::br_bl;
          else if (ins[31:24] == 8'h54) kd = bp_pkg::br_cond;
          if (kd == bp_pkg::br_cond && idx != TRACK_IDX && trained[idx]) begin
            exp_known <= 1'b0;
          end
          if (kd == bp_pkg::br_cond && !(idx == TRACK_IDX && ctr_m[1])) begin
            kd = bp_pkg::br_none;
          end
          hit_pc = spc;
          exp_kind <= kd;
          if (kd == bp_pkg::br_ret) exp_pc <= (ras_m.size() > 0) ? ras_m[$] : 64'h0;
          if (kd == bp_pkg::br_cond) exp_pc <= spc + {{43{ins[23]}}, ins[23:5], 2'b00};
          if (kd == bp_pkg::br_b || kd == bp_pkg::br_bl) begin
            exp_pc <= spc + {{36{ins[25]}}, ins[25:0], 2'b00}; // imm26 in words
          end
        end
      end
      if (kd == bp_pkg::br_bl) ras_m.push_back(hit_pc + 64'd4);
      if (ras_m.size() > `BP_RAS_DEPTH) void'(ras_m.pop_front()); // oldest falls off
      if (kd == bp_pkg::br_ret && ras_m.size() > 0) void'(ras_m.pop_back());
      if (x_valid) begin
        idx = x_pc[9:2] ^ ghr_m; // history before the shift
        trained[idx] <= 1'b1;
        if (idx == TRACK_IDX && x_taken && ctr_m != 2'd3) ctr_m <= ctr_m + 2'd1;
        if (idx == TRACK_IDX && !x_taken && ctr_m != 2'd0) ctr_m <= ctr_m - 2'd1;
        ghr_m <= {ghr_m[6:0], x_taken};
      end
    end
  end

  a_idle: assert property (@(posedge clk_in) disable iff (rst_N_in)
    !started |-> pred_pc == `BP_RESET_PC)
    else begin
      fail_count++;
      $error("Mismatch at %0t: pred_pc expected %h got %h", $time, `BP_RESET_PC,
             $sampled(pred_pc));
    end

  // pc_valid echoes line_valid or x_redirect one cycle later
  a_valid: assert property (@(posedge clk_in) disable iff (rst_N_in) pc_valid == armed)
    else begin
      fail_count++;
      $error("Mismatch at %0t: pc_valid expected %0b got %0b", $time, $sampled(armed),
             $sampled(pc_valid));
    end

  a_pc: assert property (@(posedge clk_in) disable iff (rst_N_in)
    armed && exp_known |-> pred_pc == exp_pc)
    else begin
      fail_count++;
      $error("Mismatch at %0t: pred_pc expected %h got %h", $time, $sampled(exp_pc),
             $sampled(pred_pc));
    end

  a_kind: assert property (@(posedge clk_in) disable iff (rst_N_in)
    armed && exp_known |-> pred_kind == exp_kind)
    else begin
      fail_count++;
      $error("Mismatch at %0t: pred_kind expected %0d got %0d", $time, $sampled(exp_kind),
             $sampled(pred_kind));
    end

endmodule

/* sim/fetch_predictor_tb.sv */
`include "bp_macros.svh"

module fetch_predictor_tb;

  localparam int STIM_CYCLES = 60; // directed sequence is a little over 50 cycles
  localparam int MAX_CYCLES  = 2 * STIM_CYCLES;
  localparam logic [31:0]  NOP      = 32'hd503201f;
  localparam logic [31:0]  RET      = 32'hd65f03c0;
  localparam logic [127:0] RET_LINE = {NOP, NOP, NOP, RET};
  localparam logic [63:0]  COND_PC  = 64'h2004; // slot 1 of the line at 0x2000

  logic                     clk_in;
  logic                     rst_N_in;
  logic                     line_valid;
  logic [`BP_LINE_BITS-1:0] line_data;
  logic [63:0]              line_pc;
  logic                     x_valid;
  logic [63:0]              x_pc;
  logic                     x_taken;
  logic                     x_redirect;
  logic [63:0]              x_target;
  logic [63:0]              pred_pc;
  logic                     pc_valid;
  bp_pkg::br_kind_e         pred_kind;
  integer                   seed;
  int                       cycles;
  logic [31:0]              cond_ins; // same b.cond before and after training

  fetch_predictor dut_i (.*);

  // COND_PC bits 9:2 are 8'h01, xor with an all-ones history
  bind fetch_predictor fetch_predictor_sva #(.TRACK_IDX(8'hfe)) sva_i (.*);

  always #10 clk_in = ~clk_in;

  function automatic logic [31:0] uncond_word(input logic link, input logic [25:0] imm);
    return {link, 5'b00101, imm}; // link set gives bl
  endfunction

  function automatic logic [31:0] cond_word(input logic [18:0] imm);
    return {8'h54, imm, 5'h00}; // b.eq
  endfunction

  // one-cycle pulse on line_valid, x_redirect or both
  task automatic send_pulse(input logic lv, input logic [63:0] pc,
                            input logic [`BP_LINE_BITS-1:0] data,
                            input logic rd, input logic [63:0] tgt);
    @(negedge clk_in);
    line_valid = lv;
    line_pc    = pc;
    line_data  = data;
    x_redirect = rd;
    x_target   = tgt;
    @(negedge clk_in);
    line_valid = 1'b0;
    x_redirect = 1'b0;
  endtask

  task automatic train_branch(input logic [63:0] pc, input logic taken, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_in); // back to back resolutions
      x_valid = 1'b1;
      x_pc    = pc;
      x_taken = taken;
    end
    @(negedge clk_in);
    x_valid = 1'b0;
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_in);
      cycles++;
    end
    $display("error count: %0d assertion failures, run timed out after %0d cycles",
             dut_i.sva_i.fail_count, cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed       = 32'h75f2_45fc;
    clk_in     = 1'b0;
    rst_N_in   = 1'b1;
    line_valid = 1'b0;
    line_data  = '0;
    line_pc    = '0;
    x_valid    = 1'b0;
    x_pc       = '0;
    x_taken    = 1'b0;
    x_redirect = 1'b0;
    x_target   = '0;
    cond_ins   = cond_word(19'($random(seed)));
    repeat (5) @(negedge clk_in);
    rst_N_in = 1'b0;
    repeat (4) @(negedge clk_in); // quiet, reset vector must hold
    send_pulse(1'b1, 64'h1000, {NOP, NOP, NOP, uncond_word(1'b0, 26'($random(seed)))},
               1'b0, '0);
    send_pulse(1'b1, 64'h1100, {4{NOP}}, 1'b0, '0); // sequential, base plus 16
    send_pulse(1'b1, 64'h1208, {uncond_word(1'b0, 26'($random(seed))), NOP,
               uncond_word(1'b1, 26'h10), uncond_word(1'b0, 26'h20)}, 1'b0, '0);
    // call and return, then two nested calls unwinding
    send_pulse(1'b1, 64'h3000, {NOP, NOP, uncond_word(1'b1, 26'($random(seed))), NOP},
               1'b0, '0);
    send_pulse(1'b1, 64'h4000, RET_LINE, 1'b0, '0);
    send_pulse(1'b1, 64'h5000, {NOP, NOP, NOP, uncond_word(1'b1, 26'($random(seed)))},
               1'b0, '0);
    send_pulse(1'b1, 64'h6004, {NOP, NOP, uncond_word(1'b1, 26'($random(seed))), NOP},
               1'b0, '0);
    send_pulse(1'b1, 64'h4000, RET_LINE, 1'b0, '0);
    send_pulse(1'b1, 64'h4000, RET_LINE, 1'b0, '0);
    send_pulse(1'b1, 64'h4000, RET_LINE, 1'b0, '0); // stack empty, zero
    // b.cond not taken from reset, then trained taken
    send_pulse(1'b1, 64'h2000, {NOP, NOP, cond_ins, NOP}, 1'b0, '0);
    train_branch(COND_PC, 1'b1, 10);
    send_pulse(1'b1, 64'h2000, {NOP, NOP, cond_ins, NOP}, 1'b0, '0);
    // redirect alone, then redirect squashing a call
    send_pulse(1'b0, '0, {4{NOP}}, 1'b1, {$random(seed), $random(seed)});
    send_pulse(1'b1, 64'h5000, {NOP, NOP, NOP, uncond_word(1'b1, 26'h40)}, 1'b1, 64'h9000);
    send_pulse(1'b1, 64'h4000, RET_LINE, 1'b0, '0);
    repeat (3) @(negedge clk_in);
    $display("error count: %0d assertion failures", dut_i.sva_i.fail_count);
    if (dut_i.sva_i.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+common
common/bp_pkg.sv
branch_pred/bp_predecode.sv
branch_pred/bp_gshare.sv
branch_pred/bp_ras.sv
branch_pred/bp_next_pc.sv
hw/fetch_predictor.sv
sim/fetch_predictor_sva.sv
sim/fetch_predictor_tb.sv
